//--- Bender.yml
package:
  name: superalu

export_include_dirs:
  - .

sources:
  - superalu_pkg.sv
  - alu_cmd_regs.sv
  - alu_datapath.sv
  - superalu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_superalu.sv

//--- alu_cmd_regs.sv
/*
 * superalu command block
 * latches op/mode on start, then sequences load, steps, finish and done
 */
`timescale 1ns/1ns

module alu_cmd_regs (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                start,
    input  superalu_pkg::op_e   op,
    input  superalu_pkg::mode_t mode,
    input  logic                sat,     // from datapath, load cycle only
    output superalu_pkg::op_e   op_q,
    output superalu_pkg::mode_t mode_q,
    output logic                load,
    output logic                step,
    output logic                finish,
    output logic                busy,
    output logic                done
);
    import superalu_pkg::*;

    logic             accept;            // start seen while idle
    logic [CNT_W-1:0] cnt_q;             // steps still to run
    logic [CNT_W-1:0] cnt_init;          // step count chosen at load

    assign accept = start & ~busy;       // start while busy is dropped
    assign step   = (cnt_q != '0);

    // iteration count from the latched command
    always_comb begin
        cnt_init = '0;
        if (op_q == OP_MUL) begin
            if (mode_q == MUL_PURE || mode_q == MUL_FRAC) begin
                cnt_init = CNT_W'(MPLR_W);   // shift-add over all fraction bits
            end                              // double needs no steps
        end else if (!sat) begin
            cnt_init = CNT_W'(QUOT_W);       // one step per quotient bit
        end
    end

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            op_q   <= OP_MUL;
            mode_q <= '0;
            busy   <= 1'b0;
            load   <= 1'b0;
            cnt_q  <= '0;
            finish <= 1'b0;
            done   <= 1'b0;
        end else begin
            if (accept) begin
                op_q   <= op;
                mode_q <= mode;
            end

            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;                // drops together with done rising
            end

            load <= accept;                  // single pulse after start

            if (load) begin
                cnt_q <= cnt_init;
            end else if (step) begin
                cnt_q <= cnt_q - 1'b1;
            end

            // finish right after load when nothing to iterate, else after last step
            finish <= (load && cnt_init == '0) || (step && cnt_q == CNT_W'(1));
            done   <= finish;                // same edge the result is written
        end
    end

    // datapath sees one command per cycle
    a_ctl_onehot: assert property (@(posedge CLK) disable iff (!RST_N)
        $onehot0({load, step, finish}));

    a_done_no_step: assert property (@(posedge CLK) disable iff (!RST_N)
        !(done && step));

endmodule

//--- alu_datapath.sv
/*
 * superalu datapath
 * shift-add multiply and restoring divide on one working register,
 * saturation check at load and the result register
 */
`timescale 1ns/1ns

module alu_datapath (
    input  logic                        CLK,
    input  logic                        RST_N,
    input  logic [superalu_pkg::DATA_W-1:0] x_in,
    input  logic [superalu_pkg::DATA_W-1:0] y_in,
    input  logic                        load,
    input  logic                        step,
    input  logic                        finish,
    input  superalu_pkg::op_e           op_q,
    input  superalu_pkg::mode_t         mode_q,
    output logic                        sat,
    output logic [superalu_pkg::DATA_W-1:0] result
);
    import superalu_pkg::*;

    localparam int WORK_W = $bits(work_word_u);

    logic [DATA_W-1:0] x_q;              // multiplicand / dividend
    logic [DATA_W-1:0] y_q;              // multiplier / divisor
    work_word_u        work_q;
    logic              sat_q;            // divide saturated, held to finish

    logic              idle;
    logic              is_frac;
    logic              mul_iter;         // pure or frac, runs the steps
    logic [DATA_W+1:0] mul_sum;          // acc + X before the right shift
    logic [DATA_W-1:0] mul_res;
    logic [1:0]        sat_sh;           // 9-k
    logic [3:0]        dvd_sh;           // k plus alignment into the word
    logic [WORK_W-1:0] dvd_aligned;
    logic              sat_cmp;
    logic [DATA_W:0]   rem_sh;           // remainder after the left shift
    logic [DATA_W:0]   rem_sub;
    logic              rem_ge;
    logic [DATA_W-1:0] rem_next;
    logic [DATA_W-1:0] div_res;

    assign idle     = ~(load | step | finish);
    assign is_frac  = (mode_q == MUL_FRAC);
    assign mul_iter = (mode_q == MUL_PURE) | is_frac;

    ////////////////////////////////////////////////////////////
    // multiply
    ////////////////////////////////////////////////////////////
    assign mul_sum = {1'b0, work_q.mul.acc}
                   + (work_q.mul.mplr[0] ? {2'b0, x_q} : '0);
    // frac adds the integer 1.0 part, only low bits kept
    assign mul_res = work_q.mul.acc[DATA_W-1:0] + (is_frac ? x_q : '0);

    ////////////////////////////////////////////////////////////
    // divide
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (mode_q)
            DIV_K7: begin
                sat_sh = 2'd2;
                dvd_sh = 4'd11;
            end
            DIV_K6: begin
                sat_sh = 2'd3;
                dvd_sh = 4'd10;
            end
            default: begin               // k8, code 3 too
                sat_sh = 2'd1;
                dvd_sh = 4'd12;
            end
        endcase
    end

    // quotient fits 9 bits only if X*2^k < 512*Y
    assign sat_cmp = (x_q >> sat_sh) >= y_q;   // y=0 always saturates
    assign sat     = load & (op_q == OP_DIV) & sat_cmp;

    // X*2^k placed so its low 9 bits sit at the top of dq
    assign dvd_aligned = WORK_W'(x_q) << dvd_sh;

    assign rem_sh   = {work_q.div.rem, work_q.div.dq[DATA_W-1]};
    assign rem_sub  = rem_sh - {1'b0, y_q};
    assign rem_ge   = (rem_sh >= {1'b0, y_q});
    assign rem_next = rem_ge ? rem_sub[DATA_W-1:0] : rem_sh[DATA_W-1:0];

    assign div_res  = sat_q ? DATA_W'({QUOT_W{1'b1}})
                            : {{(DATA_W-QUOT_W){1'b0}}, work_q.div.dq[QUOT_W-1:0]};

    ////////////////////////////////////////////////////////////
    // working register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (idle) begin
            x_q <= x_in;                     // tracks inputs, frozen from load on
            y_q <= y_in;
        end

        if (load) begin
            if (op_q == OP_MUL) begin
                work_q.mul.acc   <= mul_iter ? '0 : {x_q, 1'b0};  // double is 2X now
                work_q.mul.mplr  <= y_q[MPLR_W-1:0];
                work_q.mul.spare <= '0;
            end else if (!sat_cmp) begin
                {work_q.div.rem, work_q.div.dq} <= dvd_aligned;
            end
        end else if (step) begin
            if (op_q == OP_MUL) begin
                work_q.mul.acc  <= mul_sum[DATA_W+1:1];            // add then halve
                work_q.mul.mplr <= work_q.mul.mplr >> 1;
            end else begin
                work_q.div.rem <= rem_next;
                work_q.div.dq  <= {work_q.div.dq[DATA_W-2:0], rem_ge};  // new q bit
            end
        end
    end

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            sat_q  <= 1'b0;
            result <= '0;
        end else begin
            if (load) begin
                sat_q <= sat;
            end
            if (finish) begin
                result <= (op_q == OP_MUL) ? mul_res : div_res;   // held until next finish
            end
        end
    end

    // saturation must make the command block skip every divide step
    a_sat_no_step: assert property (@(posedge CLK) disable iff (!RST_N)
        step |-> !sat_q);

endmodule

//--- sources.f
+incdir+.
superalu_pkg.sv
alu_cmd_regs.sv
alu_datapath.sv
superalu_top.sv
tb_superalu.sv

//--- superalu_pkg.sv
/*
 * superalu shared definitions
 * widths, op and mode codes, the working-word union and latencies
 */
package superalu_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int DATA_W  = 13;              // operand and result word
    localparam int MPLR_W  = 8;               // multiplier fraction, also mul step count
    localparam int QUOT_W  = 9;               // quotient bits, also div step count
    localparam int CNT_W   = 4;               // step counter
    localparam int SPARE_W = 2*DATA_W - (DATA_W+1) - MPLR_W;  // pad of the mul view

    // operation select
    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } op_e;

    // mode field, meaning depends on op
    typedef logic [1:0] mode_t;

    localparam mode_t MUL_PURE   = 2'd0;     // X * 0.y
    localparam mode_t MUL_FRAC   = 2'd1;     // X * 1.y
    localparam mode_t MUL_DOUBLE = 2'd2;     // X * 2, code 3 behaves the same
    localparam mode_t DIV_K8     = 2'd0;     // X*2^8 / Y, code 3 behaves the same
    localparam mode_t DIV_K7     = 2'd1;     // X*2^7 / Y
    localparam mode_t DIV_K6     = 2'd2;     // X*2^6 / Y

    ////////////////////////////////////////////////////////////
    // working word, one register seen two ways
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [DATA_W:0]    acc;             // one guard bit above the result
        logic [MPLR_W-1:0]  mplr;            // multiplier, lsb consumed first
        logic [SPARE_W-1:0] spare;
    } mul_view_t;

    typedef struct packed {
        logic [DATA_W-1:0] rem;              // partial remainder
        logic [DATA_W-1:0] dq;               // dividend bits out, quotient bits in
    } div_view_t;

    typedef union packed {
        mul_view_t mul;
        div_view_t div;
    } work_word_u;

    // start edge to done edge
    localparam int LAT_MUL_ITER = 10;
    localparam int LAT_DIV_ITER = 11;
    localparam int LAT_SHORT    = 2;

endpackage

//--- superalu_top.sv
/*
 * superalu top level
 * command block steering the shared multiply/divide datapath
 */
`timescale 1ns/1ns

module superalu_top (
    input  logic                            CLK,
    input  logic                            RST_N,
    input  logic                            start,   // one-cycle strobe
    input  superalu_pkg::op_e               op,
    input  superalu_pkg::mode_t             mode,
    input  logic [superalu_pkg::DATA_W-1:0] x_in,
    input  logic [superalu_pkg::DATA_W-1:0] y_in,
    output logic [superalu_pkg::DATA_W-1:0] result,
    output logic                            done,    // one-cycle strobe
    output logic                            busy
);
    import superalu_pkg::*;

    op_e   op_q;
    mode_t mode_q;
    logic  load;
    logic  step;
    logic  finish;
    logic  sat;                          // divide overflow, load cycle

    alu_cmd_regs u_alu_cmd_regs (
        .CLK    (CLK),
        .RST_N  (RST_N),
        .start  (start),
        .op     (op),
        .mode   (mode),
        .sat    (sat),
        .op_q   (op_q),
        .mode_q (mode_q),
        .load   (load),
        .step   (step),
        .finish (finish),
        .busy   (busy),
        .done   (done)
    );

    alu_datapath u_alu_datapath (
        .CLK    (CLK),
        .RST_N  (RST_N),
        .x_in   (x_in),
        .y_in   (y_in),
        .load   (load),
        .step   (step),
        .finish (finish),
        .op_q   (op_q),
        .mode_q (mode_q),
        .sat    (sat),
        .result (result)
    );

endmodule

//--- tb_superalu_model.svh
/*
 * superalu reference model and compare tasks
 * xorshift generator, multiply/divide/latency model, typed checks
 */
`ifndef TB_SUPERALU_MODEL_SVH
`define TB_SUPERALU_MODEL_SVH

////////////////////////////////////////////////////////////
// random numbers
////////////////////////////////////////////////////////////
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////
// shift-add over the fraction bits, lsb first, truncating each halving
function automatic logic [DATA_W-1:0] model_mul(input logic [DATA_W-1:0] x,
                                                input logic [DATA_W-1:0] y,
                                                input mode_t mode);
    int unsigned acc;
    acc = 0;
    if (mode == MUL_PURE || mode == MUL_FRAC) begin
        for (int i = 0; i < MPLR_W; i++) begin
            if (y[i]) acc = acc + x;
            acc = acc >> 1;
        end
        if (mode == MUL_FRAC) acc = acc + x;      // the 1.0 part
    end else begin
        acc = 2 * x;                              // double, code 3 too
    end
    return DATA_W'(acc);
endfunction

function automatic int div_k(input mode_t mode);
    case (mode)
        DIV_K7:  return 7;
        DIV_K6:  return 6;
        default: return 8;
    endcase
endfunction

// quotient would need more than 9 bits, or y is zero
function automatic bit model_div_sat(input logic [DATA_W-1:0] x,
                                     input logic [DATA_W-1:0] y,
                                     input mode_t mode);
    int unsigned num;
    num = int'(x) << div_k(mode);
    if (y == '0) return 1'b1;
    return (num / y) > ((1 << QUOT_W) - 1);
endfunction

function automatic logic [DATA_W-1:0] model_div(input logic [DATA_W-1:0] x,
                                                input logic [DATA_W-1:0] y,
                                                input mode_t mode);
    int unsigned num;
    num = int'(x) << div_k(mode);
    if (model_div_sat(x, y, mode)) return DATA_W'((1 << QUOT_W) - 1);
    return DATA_W'(num / y);
endfunction

// start edge to done edge
function automatic int model_latency(input op_e op, input mode_t mode,
                                     input logic [DATA_W-1:0] x,
                                     input logic [DATA_W-1:0] y);
    if (op == OP_MUL) begin
        return (mode == MUL_PURE || mode == MUL_FRAC) ? LAT_MUL_ITER : LAT_SHORT;
    end
    return model_div_sat(x, y, mode) ? LAT_SHORT : LAT_DIV_ITER;
endfunction

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////
task automatic check_result(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
        fail_stop($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        fail_stop($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
endtask

task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
        fail_stop($sformatf("ERROR latency expected 0x%0h actual 0x%0h", exp, act));
    end
endtask

`endif

//--- tb_superalu.sv
/*
 * superalu testbench
 * random multiply/divide commands against a model, latency,
 * start-while-busy and result-hold checks
 */
`timescale 1ns/1ns

module tb_superalu;
    import superalu_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DLY    = 1;        // after the rising edge
    localparam int NUM_OPS      = 240;      // random part
    localparam int NUM_DIRECTED = 5;
    localparam int MAX_GAP      = 3;        // idle cycles after done
    localparam int WATCHDOG_NS  =
        ((NUM_OPS + NUM_DIRECTED) * (LAT_DIV_ITER + MAX_GAP + 2) + 40) * CLK_PERIOD;

    logic              CLK;
    logic              RST_N;
    logic              start;
    op_e               op;
    mode_t             mode;
    logic [DATA_W-1:0] x_in;
    logic [DATA_W-1:0] y_in;
    logic [DATA_W-1:0] result;
    logic              done;
    logic              busy;

    logic [31:0]       rng_state;
    int                n_sat;               // saturated divides seen
    int                n_div_ok;
    int                n_ignored;           // starts pulsed while busy

    superalu_top u_superalu_top (
        .CLK    (CLK),
        .RST_N  (RST_N),
        .start  (start),
        .op     (op),
        .mode   (mode),
        .x_in   (x_in),
        .y_in   (y_in),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    always #(CLK_PERIOD/2) CLK = ~CLK;

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    `include "tb_superalu_model.svh"

    task automatic draw_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    ////////////////////////////////////////////////////////////
    // one operation started 1 ns after a rising edge
    ////////////////////////////////////////////////////////////
    task automatic run_op(input op_e c_op, input mode_t c_mode,
                          input logic [DATA_W-1:0] c_x, input logic [DATA_W-1:0] c_y,
                          input bit poke_busy);
        logic [DATA_W-1:0] exp_res;
        int                exp_lat;
        int                lat;
        int                gap;
        logic [31:0]       r;
        exp_res = (c_op == OP_MUL) ? model_mul(c_x, c_y, c_mode) : model_div(c_x, c_y, c_mode);
        exp_lat = model_latency(c_op, c_mode, c_x, c_y);
        start = 1'b1;
        op    = c_op;
        mode  = c_mode;
        x_in  = c_x;
        y_in  = c_y;
        @(posedge CLK);                       // start sampled here
        #DRIVE_DLY;
        lat = 0;
        do begin
            draw_rand(r);
            x_in  = r[DATA_W-1:0];            // operands move while busy
            y_in  = r[DATA_W+15:16];
            start = 1'b0;
            if (poke_busy && lat == 1) begin
                start = 1'b1;                 // must be dropped
                op    = op_e'(r[31]);
                mode  = mode_t'(r[30:29]);
                n_ignored++;
            end
            @(posedge CLK);
            #DRIVE_DLY;
            lat++;
            if (done !== 1'b1) begin
                check_flag("busy", 1'b1, busy);
                if (lat > LAT_DIV_ITER + 4) fail_stop("done did not arrive after start");
            end
        end while (done !== 1'b1);
        start = 1'b0;
        check_latency(exp_lat, lat);
        check_result("result", exp_res, result);

        // done is one pulse and result holds while idle
        draw_rand(r);
        gap = 1 + int'(r[1:0] % MAX_GAP);
        repeat (gap) begin
            x_in = r[DATA_W+2:3];
            y_in = r[DATA_W+17:18];
            @(posedge CLK);
            #DRIVE_DLY;
            check_flag("done", 1'b0, done);
            check_flag("busy", 1'b0, busy);
            check_result("result", exp_res, result);
        end
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        fail_stop("watchdog expired before all operations completed");
    end

    ////////////////////////////////////////////////////////////
    // run sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0]       r;
        op_e               r_op;
        mode_t             r_mode;
        logic [DATA_W-1:0] r_x;
        logic [DATA_W-1:0] r_y;
        bit                r_poke;
        CLK       = 1'b0;
        RST_N     = 1'b0;
        start     = 1'b0;
        op        = OP_MUL;
        mode      = '0;
        x_in      = '0;
        y_in      = '0;
        rng_state = 32'd10;
        n_sat     = 0;
        n_div_ok  = 0;
        n_ignored = 0;
        repeat (3) @(posedge CLK);
        #DRIVE_DLY;
        RST_N = 1'b1;

        // idle state out of reset
        repeat (2) begin
            @(posedge CLK);
            #DRIVE_DLY;
            check_flag("done", 1'b0, done);
            check_flag("busy", 1'b0, busy);
            check_result("result", '0, result);
        end

        // corners first
        run_op(OP_DIV, DIV_K8, 13'h1234, 13'h0000, 1'b0);   // y = 0
        run_op(OP_DIV, DIV_K6, 13'h1fff, 13'h1fff, 1'b0);
        run_op(OP_DIV, 2'd3, 13'h00ff, 13'h0001, 1'b1);     // acts as k8 and saturates
        run_op(OP_MUL, 2'd3, 13'h1abc, 13'h00ff, 1'b1);     // acts as double
        run_op(OP_MUL, MUL_FRAC, 13'h1fff, 13'h00ff, 1'b0);

        for (int i = 0; i < NUM_OPS; i++) begin
            draw_rand(r);
            r_op   = op_e'(r[0]);
            r_mode = mode_t'(r[2:1]);
            r_poke = (r[5:3] == 3'd0);
            draw_rand(r);
            r_x = r[DATA_W-1:0];
            r_y = r[DATA_W+15:16];
            if (r_op == OP_DIV) begin
                if (r[31:29] == 3'd0) r_y = '0;
                else if (r[31:29] == 3'd1) r_y = r_y >> 6;  // small divisor
                if (model_div_sat(r_x, r_y, r_mode)) n_sat++;
                else n_div_ok++;
            end
            run_op(r_op, r_mode, r_x, r_y, r_poke);
        end

        $display("divides sat %0d, plain %0d, ignored starts %0d", n_sat, n_div_ok, n_ignored);
        if (n_sat == 0 || n_div_ok == 0 || n_ignored == 0) begin
            fail_stop("random stimulus missed saturation, plain divide or busy start");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule
